/* Bender.yml */
package:
  name: nonlinear_unit

sources:
  - nl_pkg.sv
  - stage_if.sv
  - coef_table.sv
  - word_counter.sv
  - act_sequencer.sv
  - pwl_lane.sv
  - nonlinear_unit.sv
  - target: test
    files:
      - tb_nonlinear_unit.sv

/* act_sequencer.sv */
`timescale 1ns/1ps

module act_sequencer (
	input logic clk,
	input logic reset,
	input logic start,
	input logic last,
	stage_if.seq stg,
	output logic counter_clear,
	output logic counter_step,
	output logic busy,
	output logic done_set
);
	import nl_pkg::*;

	seq_state_t state;
	seq_state_t state_nxt;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state <= idle;
		end else begin
			state <= state_nxt;
		end
	end

	always_comb begin
		state_nxt = state;
		done_set = 1'b0;
		case (state)
			idle: begin
				if (start) begin
					// empty run ends at once.
					if (last) begin
						done_set = 1'b1;
					end else begin
						state_nxt = pre_read;
					end
				end
			end
			pre_read: state_nxt = read;
			read: state_nxt = operate;
			operate: state_nxt = write;
			write: begin
				if (last) begin
					state_nxt = idle;
					done_set = 1'b1;
				end else begin
					state_nxt = pre_read;
				end
			end
			default: state_nxt = idle;
		endcase
	end

	assign stg.rd_en = state == pre_read;
	assign stg.capture = state == read;
	assign stg.compute = state == operate;
	assign stg.wr_en = state == write;

	// held at zero while idle, so a start always begins at word 0.
	assign counter_clear = state == idle;
	assign counter_step = state == write;
	assign busy = state != idle;

endmodule

/* coef_table.sv */
`timescale 1ns/1ps

module coef_table (
	input logic clk,
	input logic reset,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [nl_pkg::wb_adr_width-1:0] wb_adr,
	input logic [nl_pkg::wb_dat_width-1:0] wb_dat_w,
	output logic [nl_pkg::wb_dat_width-1:0] wb_dat_r,
	output logic wb_ack,
	input logic busy,
	output logic start,
	output logic [nl_pkg::fn_width-1:0] func,
	output logic [nl_pkg::cnt_width-1:0] word_count,
	output logic [7:0] shift_fp,
	output nl_pkg::pwl_coef_t coef,
	output logic relu_sel,
	input logic done_set,
	output logic done
);
	import nl_pkg::*;

	logic [lane_width-1:0] lut [lut_size];
	logic wb_req;
	logic code_ok;
	logic run_active;
	logic is_table;
	logic [lut_adr_width-1:0] prm_base;
	logic [lut_adr_width-1:0] seg_base;

	assign wb_req = wb_cyc && wb_stb && !wb_ack;
	assign is_table = wb_adr < lut_size;
	assign code_ok = (wb_dat_w[fn_width-1:0] == fn_relu) ||
		(wb_dat_w[fn_width-1:0] == fn_sigmoid) ||
		(wb_dat_w[fn_width-1:0] == fn_tanh);
	// a start already issued counts as busy.
	assign run_active = busy || start;

	always_ff @(posedge clk) begin
		if (wb_req && wb_we && is_table) begin
			lut[wb_adr[lut_adr_width-1:0]] <= wb_dat_w[lane_width-1:0];
		end
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			wb_ack <= 1'b0;
			start <= 1'b0;
			func <= fn_relu;
			word_count <= '0;
			shift_fp <= '0;
			done <= 1'b0;
		end else begin
			wb_ack <= wb_req;
			start <= 1'b0;
			if (done_set) begin
				done <= 1'b1;
			end
			if (wb_req && wb_we) begin
				case (wb_adr)
					reg_ctrl: begin
						if (code_ok && !run_active) begin
							func <= wb_dat_w[fn_width-1:0];
							if (wb_dat_w[ctrl_start_bit]) begin
								start <= 1'b1;
								done <= 1'b0;
							end
						end
					end
					reg_count: word_count <= wb_dat_w;
					reg_shift: shift_fp <= wb_dat_w[7:0];
					default: ;
				endcase
			end
		end
	end

	// table entries read back sign-extended.
	always_comb begin
		wb_dat_r = '0;
		if (is_table) begin
			wb_dat_r = {{(wb_dat_width-lane_width){lut[wb_adr[lut_adr_width-1:0]][lane_width-1]}},
				lut[wb_adr[lut_adr_width-1:0]]};
		end else begin
			case (wb_adr)
				reg_ctrl: wb_dat_r = {{(wb_dat_width-fn_width){1'b0}}, func};
				reg_count: wb_dat_r = word_count;
				reg_shift: wb_dat_r = {8'd0, shift_fp};
				reg_status: wb_dat_r = {14'd0, done, busy};
				default: wb_dat_r = '0;
			endcase
		end
	end

	assign prm_base = (func == fn_tanh) ? lut_adr_width'(lut_tanh_prm) : lut_adr_width'(lut_sig_prm);
	assign seg_base = (func == fn_tanh) ? lut_adr_width'(lut_tanh_seg) : lut_adr_width'(lut_sig_seg);

	// entry 0 of each set is the segment shift, not used by the lanes.
	always_comb begin
		coef.x_min = lut[prm_base + 1];
		coef.x_max = lut[prm_base + 2];
		coef.y_min = lut[prm_base + 3];
		coef.y_max = lut[prm_base + 4];
		for (int i = 0; i < n_segments; i++) begin
			coef.x_start[i] = lut[seg_base + i];
			coef.a[i] = lut[seg_base + n_segments + i];
			coef.b[i] = lut[seg_base + 2 * n_segments + i];
		end
	end

	assign relu_sel = func == fn_relu;

endmodule

/* nl_pkg.sv */
package nl_pkg;

	localparam int lane_width = 8;
	localparam int n_lanes = 4;
	localparam int word_width = lane_width * n_lanes;
	localparam int addr_width = 15;
	localparam int cnt_width = 16;
	localparam int fn_width = 3;

	localparam int lut_size = 64;
	localparam int lut_adr_width = $clog2(lut_size);
	localparam int n_segments = 8;
	localparam int seg_width = $clog2(n_segments);

	// parameter sets first, then x_start, a and b for each function.
	localparam int lut_sig_prm = 0;
	localparam int lut_tanh_prm = 5;
	localparam int lut_sig_seg = 10;
	localparam int lut_tanh_seg = 34;

	localparam int wb_adr_width = 7;
	localparam int wb_dat_width = 16;

	localparam logic [wb_adr_width-1:0] reg_ctrl = 7'd64;
	localparam logic [wb_adr_width-1:0] reg_count = 7'd65;
	localparam logic [wb_adr_width-1:0] reg_shift = 7'd66;
	localparam logic [wb_adr_width-1:0] reg_status = 7'd67;
	localparam int ctrl_start_bit = 8;

	localparam logic [fn_width-1:0] fn_relu = 3'd0;
	localparam logic [fn_width-1:0] fn_sigmoid = 3'd3;
	localparam logic [fn_width-1:0] fn_tanh = 3'd4;

	typedef enum logic [2:0] {
		idle,
		pre_read,
		read,
		operate,
		write
	} seq_state_t;

	typedef struct packed {
		logic [lane_width-1:0] x_min;
		logic [lane_width-1:0] x_max;
		logic [lane_width-1:0] y_min;
		logic [lane_width-1:0] y_max;
		logic [n_segments-1:0][lane_width-1:0] x_start;
		logic [n_segments-1:0][lane_width-1:0] a;
		logic [n_segments-1:0][lane_width-1:0] b;
	} pwl_coef_t;

endpackage

/* nonlinear_unit.f */
nl_pkg.sv
stage_if.sv
coef_table.sv
word_counter.sv
act_sequencer.sv
pwl_lane.sv
nonlinear_unit.sv
tb_nonlinear_unit.sv

/* nonlinear_unit.sv */
`timescale 1ns/1ps

module nonlinear_unit #(
	parameter int lane_count = nl_pkg::n_lanes
) (
	input logic clk,
	input logic reset,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [nl_pkg::wb_adr_width-1:0] wb_adr,
	input logic [nl_pkg::wb_dat_width-1:0] wb_dat_w,
	output logic [nl_pkg::wb_dat_width-1:0] wb_dat_r,
	output logic wb_ack,
	output logic src_rd_en,
	output logic [nl_pkg::addr_width-1:0] src_rd_addr,
	input logic [lane_count*nl_pkg::lane_width-1:0] src_rd_data,
	output logic dst_wr_en,
	output logic [nl_pkg::addr_width-1:0] dst_wr_addr,
	output logic [lane_count*nl_pkg::lane_width-1:0] dst_wr_data,
	output logic done
);
	import nl_pkg::*;

	stage_if stg ();

	logic start;
	logic busy;
	logic done_set;
	logic last;
	logic counter_clear;
	logic counter_step;
	logic relu_sel;
	logic [fn_width-1:0] func;
	logic [cnt_width-1:0] word_count;
	logic [7:0] shift_fp;
	logic [addr_width-1:0] index;
	pwl_coef_t coef;

	coef_table u_coef_table (
		.clk(clk),
		.reset(reset),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack),
		.busy(busy),
		.start(start),
		.func(func),
		.word_count(word_count),
		.shift_fp(shift_fp),
		.coef(coef),
		.relu_sel(relu_sel),
		.done_set(done_set),
		.done(done)
	);

	word_counter u_word_counter (
		.clk(clk),
		.reset(reset),
		.clear(counter_clear),
		.step(counter_step),
		.word_count(word_count),
		.index(index),
		.last(last)
	);

	act_sequencer u_act_sequencer (
		.clk(clk),
		.reset(reset),
		.start(start),
		.last(last),
		.stg(stg.seq),
		.counter_clear(counter_clear),
		.counter_step(counter_step),
		.busy(busy),
		.done_set(done_set)
	);

	// one word in flight, so read and write share the index.
	assign src_rd_en = stg.rd_en;
	assign src_rd_addr = index;
	assign dst_wr_en = stg.wr_en;
	assign dst_wr_addr = index;

	for (genvar g = 0; g < lane_count; g++) begin : g_lane
		pwl_lane u_pwl_lane (
			.clk(clk),
			.reset(reset),
			.capture(stg.capture),
			.compute(stg.compute),
			.x_in(src_rd_data[g*lane_width +: lane_width]),
			.coef(coef),
			.relu_sel(relu_sel),
			.shift_fp(shift_fp),
			.y(dst_wr_data[g*lane_width +: lane_width])
		);
	end

endmodule

/* pwl_lane.sv */
`timescale 1ns/1ps

module pwl_lane (
	input logic clk,
	input logic reset,
	input logic capture,
	input logic compute,
	input logic signed [nl_pkg::lane_width-1:0] x_in,
	input nl_pkg::pwl_coef_t coef,
	input logic relu_sel,
	input logic [7:0] shift_fp,
	output logic signed [nl_pkg::lane_width-1:0] y
);
	import nl_pkg::*;

	logic signed [lane_width-1:0] x_q;
	logic [seg_width-1:0] seg;
	logic signed [lane_width-1:0] a_sel;
	logic signed [lane_width-1:0] b_sel;
	logic signed [2*lane_width-1:0] prod;
	logic signed [2*lane_width-1:0] b_shl;
	logic signed [2*lane_width-1:0] acc;
	logic signed [lane_width-1:0] pwl_y;
	logic signed [lane_width-1:0] y_nxt;

	// highest segment starting at or below x.
	always_comb begin
		seg = '0;
		for (int i = 0; i < n_segments; i++) begin
			if ($signed(coef.x_start[i]) <= x_q) begin
				seg = seg_width'(i);
			end
		end
	end

	assign a_sel = coef.a[seg];
	assign b_sel = coef.b[seg];

	// 16-bit sum with b aligned to the product.
	assign prod = a_sel * x_q;
	assign b_shl = b_sel <<< shift_fp;
	assign acc = (prod + b_shl) >>> shift_fp;
	assign pwl_y = acc[lane_width-1:0];

	always_comb begin
		if (relu_sel) begin
			y_nxt = (x_q > 0) ? x_q : '0;
		end else if (x_q <= $signed(coef.x_min)) begin
			y_nxt = coef.y_min;
		end else if (x_q >= $signed(coef.x_max)) begin
			y_nxt = coef.y_max;
		end else begin
			y_nxt = pwl_y;
		end
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			x_q <= '0;
			y <= '0;
		end else begin
			if (capture) begin
				x_q <= x_in;
			end
			if (compute) begin
				y <= y_nxt;
			end
		end
	end

endmodule

/* stage_if.sv */
`timescale 1ns/1ps

// per-word strobes, one per sequencer state.
interface stage_if;

	logic rd_en;
	logic capture;
	logic compute;
	logic wr_en;

	modport seq (
		output rd_en,
		output capture,
		output compute,
		output wr_en
	);

	modport dp (
		input rd_en,
		input capture,
		input compute,
		input wr_en
	);

endinterface

/* tb_nonlinear_unit.sv */
`timescale 1ns/1ps

module tb_nonlinear_unit;
	import nl_pkg::*;

	localparam int run_words = 40;
	localparam int total_words = 3 * run_words + 10;
	localparam int watchdog_cycles = total_words * 4 + 2000;

	logic clk;
	logic reset;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [wb_adr_width-1:0] wb_adr;
	logic [wb_dat_width-1:0] wb_dat_w;
	logic [wb_dat_width-1:0] wb_dat_r;
	logic wb_ack;
	logic src_rd_en;
	logic [addr_width-1:0] src_rd_addr;
	logic [word_width-1:0] src_rd_data;
	logic dst_wr_en;
	logic [addr_width-1:0] dst_wr_addr;
	logic [word_width-1:0] dst_wr_data;
	logic done;

	logic [word_width-1:0] src_mem [256];
	logic [word_width-1:0] dst_mem [256];
	int wr_hits [256];
	logic signed [lane_width-1:0] tbl [lut_size];
	logic [7:0] cur_shift;
	logic rd_pend = 1'b0;
	logic [addr_width-1:0] rd_addr_q;
	integer seed = 89;
	int errors = 0;
	int checks = 0;
	int wr_total = 0;
	int cycle_no = 0;
	int last_wr_cycle = -1;

	nonlinear_unit u_nonlinear_unit (
		.clk(clk),
		.reset(reset),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack),
		.src_rd_en(src_rd_en),
		.src_rd_addr(src_rd_addr),
		.src_rd_data(src_rd_data),
		.dst_wr_en(dst_wr_en),
		.dst_wr_addr(dst_wr_addr),
		.dst_wr_data(dst_wr_data),
		.done(done)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_no = cycle_no + 1;
	end

	// source memory model with one cycle of read latency.
	always @(negedge clk) begin
		if (rd_pend) begin
			src_rd_data = src_mem[rd_addr_q[7:0]];
		end
		rd_pend = src_rd_en;
		rd_addr_q = src_rd_addr;
	end

	// destination memory and write spacing.
	always @(negedge clk) begin
		if (reset && dst_wr_en) begin
			if (last_wr_cycle >= 0 && cycle_no - last_wr_cycle != 4) begin
				$display("[ERROR] write spacing: expected 4, actual %0d",
					cycle_no - last_wr_cycle);
				errors++;
			end
			if (dst_wr_addr > 255) begin
				$display("write to address %0d is outside the destination memory", dst_wr_addr);
				errors++;
			end
			last_wr_cycle = cycle_no;
			dst_mem[dst_wr_addr[7:0]] = dst_wr_data;
			wr_hits[dst_wr_addr[7:0]]++;
			wr_total++;
		end
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("timeout: the run did not finish within %0d cycles", watchdog_cycles);
		$display("TEST FAILED");
		$finish;
	end

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (exp !== act) begin
			$display("[ERROR] %s: expected %h, actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic wb_write(input logic [wb_adr_width-1:0] adr, input logic [15:0] dat);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = 1'b1;
		wb_adr = adr;
		wb_dat_w = dat;
		@(negedge clk);
		while (!wb_ack) @(negedge clk);
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		@(negedge clk);
	endtask

	task automatic wb_read(input logic [wb_adr_width-1:0] adr, output logic [15:0] dat);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = 1'b0;
		wb_adr = adr;
		@(negedge clk);
		while (!wb_ack) @(negedge clk);
		dat = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		@(negedge clk);
	endtask

	task automatic table_write(input int idx, input logic [7:0] val);
		wb_write(wb_adr_width'(idx), {8'd0, val});
		tbl[idx] = val;
	endtask

	function automatic logic signed [7:0] lane_model(input logic signed [7:0] x,
			input logic [2:0] fn);
		int prm;
		int sb;
		int seg;
		logic signed [15:0] prod;
		logic signed [15:0] b_ext;
		logic signed [15:0] sum;
		prm = (fn == fn_tanh) ? lut_tanh_prm : lut_sig_prm;
		sb = (fn == fn_tanh) ? lut_tanh_seg : lut_sig_seg;
		if (fn == fn_relu) return (x > 0) ? x : 8'sd0;
		if (x <= tbl[prm + 1]) return tbl[prm + 3];
		if (x >= tbl[prm + 2]) return tbl[prm + 4];
		seg = 0;
		for (int i = 0; i < n_segments; i++) begin
			if (tbl[sb + i] <= x) seg = i;
		end
		prod = tbl[sb + n_segments + seg] * x;
		b_ext = tbl[sb + 2 * n_segments + seg];
		sum = (prod + (b_ext <<< cur_shift)) >>> cur_shift;
		return sum[7:0];
	endfunction

	function automatic logic [31:0] word_model(input logic [31:0] w, input logic [2:0] fn);
		logic [31:0] r;
		for (int l = 0; l < n_lanes; l++) begin
			r[l*8 +: 8] = lane_model(w[l*8 +: 8], fn);
		end
		return r;
	endfunction

	// start points rise by about 24 per segment between clamps near -100 and 100.
	task automatic load_params(input logic [2:0] fn);
		int prm;
		int sb;
		prm = (fn == fn_tanh) ? lut_tanh_prm : lut_sig_prm;
		sb = (fn == fn_tanh) ? lut_tanh_seg : lut_sig_seg;
		table_write(prm, $random(seed));
		table_write(prm + 1, -100 - ($random(seed) & 15));
		table_write(prm + 2, 100 + ($random(seed) & 15));
		table_write(prm + 3, $random(seed));
		table_write(prm + 4, $random(seed));
		for (int i = 0; i < n_segments; i++) begin
			table_write(sb + i, -96 + 24 * i + ($random(seed) & 15));
			table_write(sb + n_segments + i, $random(seed));
			table_write(sb + 2 * n_segments + i, $random(seed));
		end
	endtask

	task automatic fill_source();
		for (int i = 0; i < 256; i++) begin
			src_mem[i] = $random(seed);
		end
	endtask

	task automatic run_and_check(input logic [2:0] fn, input int count, input string name,
			input bit second_start);
		logic [15:0] status;
		for (int i = 0; i < 256; i++) begin
			wr_hits[i] = 0;
		end
		wr_total = 0;
		last_wr_cycle = -1;
		wb_write(reg_count, count);
		wb_write(reg_ctrl, 16'h0100 | fn);
		if (second_start) begin
			while (wr_total < 3) @(negedge clk);
			wb_write(reg_ctrl, 16'h0100 | fn_tanh);
		end
		while (!done) @(negedge clk);
		// done follows the final write by one cycle.
		if (count > 0) begin
			check_value({name, " done delay"}, 1, cycle_no - last_wr_cycle);
		end
		for (int i = 0; i < count; i++) begin
			if (wr_hits[i] != 1) begin
				$display("%s: address %0d was written %0d times", name, i, wr_hits[i]);
				errors++;
			end
			check_value(name, word_model(src_mem[i], fn), dst_mem[i]);
		end
		check_value({name, " writes"}, count, wr_total);
		wb_read(reg_status, status);
		check_value({name, " status"}, 32'h2, status);
	endtask

	initial begin
		logic [15:0] rd;
		logic [15:0] cnt;
		logic [15:0] sh;
		reset = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		src_rd_data = '0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset = 1'b1;
		@(negedge clk);

		wb_read(reg_status, rd);
		check_value("status after reset", 0, rd);
		for (int i = 0; i < lut_size; i++) begin
			table_write(i, $random(seed));
		end
		cnt = $random(seed);
		sh = $random(seed);
		wb_write(reg_count, cnt);
		wb_write(reg_shift, sh);
		for (int i = 0; i < lut_size; i++) begin
			wb_read(i, rd);
			check_value("table readback", {{8{tbl[i][7]}}, tbl[i]}, rd);
		end
		wb_read(reg_count, rd);
		check_value("count readback", cnt, rd);
		wb_read(reg_shift, rd);
		check_value("shift readback", {8'd0, sh[7:0]}, rd);

		cur_shift = 8'd4;
		wb_write(reg_shift, cur_shift);
		fill_source();
		run_and_check(fn_relu, run_words, "relu run", 1'b0);
		load_params(fn_sigmoid);
		fill_source();
		run_and_check(fn_sigmoid, run_words, "sigmoid run", 1'b0);
		load_params(fn_tanh);
		fill_source();
		run_and_check(fn_tanh, run_words, "tanh run", 1'b0);

		// function code 1 is not a valid code.
		wr_total = 0;
		wb_write(reg_ctrl, 16'h0101);
		repeat (20) @(negedge clk);
		check_value("bad code writes", 0, wr_total);
		wb_read(reg_status, rd);
		check_value("bad code busy", 0, rd[0]);
		wb_read(reg_ctrl, rd);
		check_value("bad code func", fn_tanh, rd);

		run_and_check(fn_relu, 0, "empty run", 1'b0);
		run_and_check(fn_relu, 10, "start while busy", 1'b1);

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* word_counter.sv */
`timescale 1ns/1ps

module word_counter (
	input logic clk,
	input logic reset,
	input logic clear,
	input logic step,
	input logic [nl_pkg::cnt_width-1:0] word_count,
	output logic [nl_pkg::addr_width-1:0] index,
	output logic last
);
	import nl_pkg::*;

	logic [cnt_width-1:0] index_next;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			index <= '0;
		end else if (clear) begin
			index <= '0;
		end else if (step) begin
			index <= index + 1'b1;
		end
	end

	// compares the index after this step, so a cleared
	// counter with a count of zero is already at the end.
	assign index_next = cnt_width'(index) + cnt_width'(step);
	assign last = index_next == word_count;

endmodule
